/* cart_loader_sva.sv */
//====================
// Cartridge loader assertions
//====================
`timescale 1ns/1ps
`default_nettype none

module cart_loader_sva (
	input logic clk_sys,
	input logic RESET,
	input logic core_reset,
	input logic clear_busy,
	input logic clear_we,
	input logic code_valid
);

	int fails = 0;

	// RAM writes only inside the sweep
	we_in_sweep: assert property (@(posedge clk_sys) disable iff (RESET) clear_we |-> clear_busy)
		else begin
			fails++;
			$error("clear_we high without clear_busy");
		end

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else begin
			fails++;
			$error("code_valid longer than one cycle");
		end

	// Core stays held for the whole clear
	busy_holds_core: assert property (@(posedge clk_sys) disable iff (RESET)
		clear_busy |-> core_reset)
		else begin
			fails++;
			$error("clear_busy without core_reset");
		end

endmodule

`default_nettype wire

/* cart_loader_top.sv */
//====================
// Cartridge loader
//====================
`timescale 1ns/1ps
`default_nettype none

`include "snes_cfg.svh"

module cart_loader_top
	import snes_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      dl_download,
	input  logic [7:0]                dl_index,
	input  logic [24:0]               dl_addr,
	input  logic [15:0]               dl_data,
	input  logic                      dl_wr,
	input  logic [2:0]                hdr_mode,
	input  logic [1:0]                region_opt,
	input  logic [1:0]                wram_pat,
	input  logic [1:0]                aram_pat,
	output logic                      core_reset,
	output logic [7:0]                rom_type,
	output logic [23:0]               rom_mask,
	output logic [23:0]               ram_mask,
	output logic [3:0]                ram_size_code,
	output logic                      pal,
	output logic                      clear_busy,
	output logic                      clear_we,
	output logic [`CLR_ADDR_BITS-1:0] clear_addr,
	output logic [7:0]                wram_fill,
	output logic [7:0]                aram_fill,
	output logic [31:0]               code_flags,
	output logic [31:0]               code_addr,
	output logic [31:0]               code_cmp,
	output logic [31:0]               code_repl,
	output logic                      code_valid,
	output logic                      code_reset
);

	cheat_rec_u code;

	dl_bus_if i_dl_bus ();

	download_router i_download_router (
		.clk_sys(clk_sys), .RESET(RESET), .dl_download(dl_download), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr), .clear_busy(clear_busy),
		.bus(i_dl_bus.router), .core_reset(core_reset)
	);

	rom_header_detect i_rom_header_detect (
		.clk_sys(clk_sys), .RESET(RESET), .bus(i_dl_bus.sink),
		.hdr_mode(hdr_mode_e'(hdr_mode)), .region_opt(region_opt), .rom_type(rom_type),
		.rom_size_code(), .ram_size_code(ram_size_code), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .pal(pal)
	);

	ram_clear_seq i_ram_clear_seq (
		.clk_sys(clk_sys), .RESET(RESET), .bus(i_dl_bus.sink),
		.wram_pat(fill_pat_e'(wram_pat)), .aram_pat(fill_pat_e'(aram_pat)),
		.clear_busy(clear_busy), .clear_we(clear_we), .clear_addr(clear_addr),
		.wram_fill(wram_fill), .aram_fill(aram_fill)
	);

	cheat_code_asm i_cheat_code_asm (
		.clk_sys(clk_sys), .RESET(RESET), .bus(i_dl_bus.sink), .code(code),
		.code_valid(code_valid), .code_reset(code_reset)
	);

	// Field view of the assembled record
	assign code_flags = code.f.flags;
	assign code_addr  = code.f.addr;
	assign code_cmp   = code.f.cmp;
	assign code_repl  = code.f.repl;

endmodule

`default_nettype wire

/* cheat_code_asm.sv */
//====================
// Cheat record assembly
//====================
`timescale 1ns/1ps
`default_nettype none

module cheat_code_asm
	import snes_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	dl_bus_if.sink     bus,
	output cheat_rec_u code,
	output logic       code_valid,
	output logic       code_reset
);

	logic code_wr;

	assign code_wr = bus.code_dl & bus.wr;

	// Strobes
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			// Replace high word closes the record
			code_valid <= code_wr && bus.addr[3:0] == 4'd14;
			code_reset <= (code_wr && bus.addr == 25'd0) || bus.cart_dl;
		end
	end

	// Old codes do not survive a new cartridge
	always_ff @(posedge clk_sys) begin
		if (bus.cart_end)
			code <= '0;
		else if (code_wr)
			code.words[bus.addr[3:1]] <= bus.data;
	end

endmodule

`default_nettype wire

/* dl_bus_if.sv */
//====================
// Decoded download bus
//====================
`timescale 1ns/1ps
`default_nettype none

interface dl_bus_if;
	logic [24:0] addr;
	logic [15:0] data;
	logic        wr;
	// Download kinds
	logic        cart_dl;
	logic        code_dl;
	logic        spc_dl;
	// Cartridge download edges
	logic        cart_start;
	logic        cart_end;

	modport router (output addr, data, wr, cart_dl, code_dl, spc_dl, cart_start, cart_end);

	modport sink (input addr, data, wr, cart_dl, code_dl, spc_dl, cart_start, cart_end);
endinterface

`default_nettype wire

/* download_router.sv */
//====================
// Download channel decode
//====================
`timescale 1ns/1ps
`default_nettype none

`include "snes_cfg.svh"

module download_router (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_download,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	input  logic        dl_wr,
	input  logic        clear_busy,
	dl_bus_if.router    bus,
	output logic        core_reset
);

	logic cart_dl;
	logic spc_dl;
	logic cart_dl_q;

	// An all-zero index is also a cartridge
	assign cart_dl = dl_download & ((dl_index[5:0] == `DL_IDX_CART) | (dl_index == 8'h00));
	assign spc_dl  = dl_download & (dl_index[5:0] == `DL_IDX_SPC);

	assign bus.cart_dl = cart_dl;
	assign bus.spc_dl  = spc_dl;
	assign bus.code_dl = dl_download & (dl_index == `DL_IDX_CODE);
	assign bus.addr    = dl_addr;
	assign bus.data    = dl_data;
	assign bus.wr      = dl_wr;

	// Edges against the previous cartridge level
	assign bus.cart_start = cart_dl & ~cart_dl_q;
	assign bus.cart_end   = ~cart_dl & cart_dl_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			cart_dl_q <= cart_dl;
			// Console core waits for loading and clearing to finish
			core_reset <= cart_dl | spc_dl | clear_busy;
		end
	end

endmodule

`default_nettype wire

/* ram_clear_seq.sv */
//====================
// Work and sound RAM clear
//====================
`timescale 1ns/1ps
`default_nettype none

`include "snes_cfg.svh"

module ram_clear_seq
	import snes_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      RESET,
	dl_bus_if.sink                    bus,
	input  fill_pat_e                 wram_pat,
	input  fill_pat_e                 aram_pat,
	output logic                      clear_busy,
	output logic                      clear_we,
	output logic [`CLR_ADDR_BITS-1:0] clear_addr,
	output logic [7:0]                wram_fill,
	output logic [7:0]                aram_fill
);

	logic [`CLR_ADDR_BITS-1:0] addr_nxt;

	function automatic logic [7:0] fill_byte(input fill_pat_e pat,
		input logic [`CLR_ADDR_BITS-1:0] a);
		case (pat)
			SNES2_9966: fill_byte = (a[8] ^ a[2]) ? `FILL_66 : `FILL_99;
			SNES1_00FF: fill_byte = (a[9] ^ a[0]) ? `FILL_FF : `FILL_00;
			SD2_55:     fill_byte = `FILL_55;
			default:    fill_byte = `FILL_FF;
		endcase
	endfunction

	// Address steps on the second cycle of each pair
	always_comb begin
		addr_nxt = clear_addr;
		if (bus.cart_start)
			addr_nxt = '0;
		else if (clear_busy && !clear_we)
			addr_nxt = clear_addr + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clear_busy <= 1'b0;
			clear_we   <= 1'b0;
			clear_addr <= '0;
		end else begin
			clear_addr <= addr_nxt;
			if (bus.cart_start) begin
				clear_busy <= 1'b1;
				clear_we   <= 1'b1;
			end else if (clear_busy) begin
				clear_we <= ~clear_we & ~(&clear_addr);
				if (!clear_we && &clear_addr)
					clear_busy <= 1'b0;
			end
		end
	end

	// Fill bytes line up with the registered address
	always_ff @(posedge clk_sys) begin
		wram_fill <= fill_byte(wram_pat, addr_nxt);
		aram_fill <= fill_byte(aram_pat, addr_nxt);
	end

endmodule

`default_nettype wire

/* rom_header_detect.sv */
//====================
// ROM header detection
//====================
`timescale 1ns/1ps
`default_nettype none

`include "snes_cfg.svh"

module rom_header_detect
	import snes_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	dl_bus_if.sink      bus,
	input  hdr_mode_e   hdr_mode,
	input  logic [1:0]  region_opt,
	output logic [7:0]  rom_type,
	output logic [3:0]  rom_size_code,
	output logic [3:0]  ram_size_code,
	output logic [23:0] rom_mask,
	output logic [23:0] ram_mask,
	output logic        pal
);

	logic [24:0] size_addr;
	logic        size_en;
	logic        hdr_wr;
	logic        region_q;

	assign hdr_wr = bus.cart_dl & bus.wr;

	// Size word location of the forced layouts
	always_comb begin
		size_en   = 1'b1;
		size_addr = '0;
		case (hdr_mode)
			LOROM:   size_addr = `HDR_LO_SIZE_ADDR;
			HIROM:   size_addr = `HDR_HI_SIZE_ADDR;
			EXHIROM: size_addr = `HDR_EX_SIZE_ADDR;
			default: size_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type      <= 8'h00;
			rom_size_code <= `HDR_DEF_ROM_SIZE;
			ram_size_code <= 4'h0;
			region_q      <= 1'b0;
			pal           <= 1'b0;
		end else begin
			if (hdr_wr && bus.addr == 25'd0) begin
				rom_size_code <= `HDR_DEF_ROM_SIZE;
				ram_size_code <= 4'h0;
				// Loader puts the size byte in front of the image
				if (hdr_mode == AUTO && bus.data[7:0] != 8'h00)
					{ram_size_code, rom_size_code} <= bus.data[7:0];
				case (hdr_mode)
					LOROM_NOHDR, LOROM: rom_type <= 8'd0;
					HIROM:              rom_type <= 8'd1;
					EXHIROM:            rom_type <= 8'd2;
					default:            rom_type <= bus.data[15:8];
				endcase
			end
			if (hdr_wr && bus.addr == 25'd2)
				region_q <= bus.data[8];
			if (hdr_wr && size_en && bus.addr == size_addr)
				rom_size_code <= bus.data[11:8];
			if (hdr_wr && size_en && bus.addr == size_addr + 25'd2)
				ram_size_code <= bus.data[3:0];

			// Video region is held for the whole download
			if (!bus.cart_dl)
				pal <= (region_opt == 2'd0) ? region_q : region_opt[1];
		end
	end

	assign rom_mask = (24'd1024 << rom_size_code) - 24'd1;
	assign ram_mask = (ram_size_code == 4'h0) ? 24'd0 : (24'd1024 << ram_size_code) - 24'd1;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module tb_cart_loader \
	-o sim_cart_loader

./obj_dir/sim_cart_loader +verilator+error+limit+100 | tee sim.log

# The log decides the result
grep -q "^SIMULATION PASSED$" sim.log

/* snes_cfg.svh */
//====================
// Cartridge loader constants
//====================
`ifndef SNES_CFG_SVH
`define SNES_CFG_SVH

// Download channel indexes
`define DL_IDX_CART 6'h01
`define DL_IDX_SPC  6'h04
`define DL_IDX_CODE 8'hFF

// Copier header in front of the ROM image
`define HDR_COPIER_OFS 25'h200

// ROM-size word per layout with the RAM-size word two bytes higher
`define HDR_LO_SIZE_ADDR (25'h7FD6 + `HDR_COPIER_OFS)
`define HDR_HI_SIZE_ADDR (25'hFFD6 + `HDR_COPIER_OFS)
`define HDR_EX_SIZE_ADDR (25'h40FFD6 + `HDR_COPIER_OFS)

`define HDR_DEF_ROM_SIZE 4'hC

// Work RAM / sound RAM clear sweep
`define CLR_ADDR_BITS 18
`define FILL_66 8'h66
`define FILL_99 8'h99
`define FILL_55 8'h55
`define FILL_FF 8'hFF
`define FILL_00 8'h00

`endif

/* snes_pkg.sv */
//====================
// Cartridge loader types
//====================
`default_nettype none

package snes_pkg;

	// ROM header detection mode
	typedef enum logic [2:0] {
		AUTO        = 3'd0,
		LOROM_NOHDR = 3'd1,
		LOROM       = 3'd2,
		HIROM       = 3'd3,
		EXHIROM     = 3'd4
	} hdr_mode_e;

	// Power-on RAM contents
	typedef enum logic [1:0] {
		SNES2_9966 = 2'd0,
		SNES1_00FF = 2'd1,
		SD2_55     = 2'd2,
		ALL_FF     = 2'd3
	} fill_pat_e;

	// Flags in the lowest word so the word view indexes by download offset
	typedef union packed {
		logic [7:0][15:0] words;
		struct packed {
			logic [31:0] repl;
			logic [31:0] cmp;
			logic [31:0] addr;
			logic [31:0] flags;
		} f;
	} cheat_rec_u;

endpackage

`default_nettype wire

/* sources.f */
+incdir+.
snes_pkg.sv
dl_bus_if.sv
download_router.sv
rom_header_detect.sv
ram_clear_seq.sv
cheat_code_asm.sv
cart_loader_top.sv
cart_loader_sva.sv
tb_cart_loader.sv

/* tb_cart_loader.sv */
//====================
// Cartridge loader testbench
//====================
`timescale 1ns/1ps
`default_nettype none

`include "snes_cfg.svh"

module tb_cart_loader;

	localparam int SWEEP_CYCLES = 2 << `CLR_ADDR_BITS;

	logic        clk_sys = 1'b0;
	logic        RESET;
	logic        dl_download;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic        dl_wr;
	logic [2:0]  hdr_mode;
	logic [1:0]  region_opt;
	logic [1:0]  wram_pat;
	logic [1:0]  aram_pat;
	logic        core_reset;
	logic [7:0]  rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic [3:0]  ram_size_code;
	logic        pal;
	logic        clear_busy;
	logic        clear_we;
	logic [17:0] clear_addr;
	logic [7:0]  wram_fill;
	logic [7:0]  aram_fill;
	logic [31:0] code_flags;
	logic [31:0] code_addr;
	logic [31:0] code_cmp;
	logic [31:0] code_repl;
	logic        code_valid;
	logic        code_reset;

	int errors = 0;
	int timeouts = 0;
	int seed = 22993;
	int we_count = 0;
	int valid_count = 0;
	logic have_prev = 1'b0;
	logic prev_reset;
	logic [17:0] last_addr;
	logic [7:0][15:0] code_words;

	always #20 clk_sys = ~clk_sys;

	cart_loader_top i_cart_loader_top (.*);

	bind cart_loader_top cart_loader_sva i_cart_loader_sva (
		.clk_sys(clk_sys), .RESET(RESET), .core_reset(core_reset), .clear_busy(clear_busy),
		.clear_we(clear_we), .code_valid(code_valid)
	);

	//====================
	// Reference rules
	//====================
	// 1 KiB shifted by the size code and no RAM for RAM code 0
	function automatic logic [23:0] size_mask(input logic [3:0] code, input logic zero_empty);
		logic [31:0] bytes;
		bytes = 32'd1024 << code;
		if (zero_empty && code == 4'h0)
			size_mask = 24'h0;
		else
			size_mask = bytes[23:0] - 24'd1;
	endfunction

	function automatic logic [7:0] fill_ref(input logic [1:0] pat, input logic [17:0] a);
		case (pat)
			2'd0: fill_ref = (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1: fill_ref = (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2: fill_ref = 8'h55;
			default: fill_ref = 8'hFF;
		endcase
	endfunction

	// Cartridge or sound program download
	function automatic logic is_load_kind(input logic dl, input logic [7:0] idx);
		is_load_kind = dl && (idx[5:0] == 6'h01 || idx == 8'h00 || idx[5:0] == 6'h04);
	endfunction

	// Flags, address, compare and replace from the low word up
	function automatic logic [31:0] record_field(input logic [7:0][15:0] w, input logic [1:0] n);
		case (n)
			2'd0: record_field = {w[1], w[0]};
			2'd1: record_field = {w[3], w[2]};
			2'd2: record_field = {w[5], w[4]};
			default: record_field = {w[7], w[6]};
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic timed_out(input string what);
		timeouts++;
		$display("Timeout while waiting for %s at %0d ns", what, $time);
	endtask

	//====================
	// Stimulus
	//====================
	task automatic begin_download(input logic [7:0] idx);
		@(posedge clk_sys);
		#2;
		dl_download = 1'b1;
		dl_index = idx;
	endtask

	task automatic write_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		#2;
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b0;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		#2;
		dl_download = 1'b0;
	endtask

	// Size words only go out when a layout address is given
	task automatic load_header(input logic [2:0] mode, input logic [7:0] idx,
		input logic [15:0] w0, input logic [24:0] sz_addr, input logic [3:0] rs,
		input logic [3:0] ms);
		begin_download(idx);
		hdr_mode = mode;
		write_word(25'd0, w0);
		write_word(25'd2, 16'h0100);
		if (sz_addr != 25'd0) begin
			write_word(sz_addr, {4'h0, rs, 8'h00});
			write_word(sz_addr + 25'd2, {12'h0, ms});
		end
		end_download();
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_header(input logic [7:0] typ, input logic [3:0] rs,
		input logic [3:0] ms);
		check("rom_type", 32'(rom_type), 32'(typ));
		check("rom_mask", 32'(rom_mask), 32'(size_mask(rs, 1'b0)));
		check("ram_mask", 32'(ram_mask), 32'(size_mask(ms, 1'b1)));
		check("ram_size_code", 32'(ram_size_code), 32'(ms));
	endtask

	task automatic run_sweep(input logic [1:0] wpat, input logic [1:0] apat);
		int n;
		begin_download(8'h01);
		wram_pat = wpat;
		aram_pat = apat;
		n = 0;
		while (!clear_busy && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (!clear_busy)
			timed_out("clear start");
		n = 0;
		while (clear_busy && n < SWEEP_CYCLES + 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (clear_busy)
			timed_out("clear end");
		check("clear busy cycles", n, SWEEP_CYCLES);
		check("clear writes", we_count, 1 << `CLR_ADDR_BITS);
		end_download();
	endtask

	// Per-cycle compare of reset, sweep address and fill bytes
	always @(negedge clk_sys) begin
		if (have_prev)
			check("core_reset", 32'(core_reset), 32'(prev_reset));
		prev_reset = RESET | is_load_kind(dl_download, dl_index) | clear_busy;
		have_prev = 1'b1;
		if (code_valid)
			valid_count++;
		if (clear_we) begin
			if (clear_addr != 18'd0)
				check("clear_addr", 32'(clear_addr), 32'(last_addr + 18'd1));
			we_count = (clear_addr == 18'd0) ? 1 : we_count + 1;
			last_addr = clear_addr;
			check("wram_fill", 32'(wram_fill), 32'(fill_ref(wram_pat, clear_addr)));
			check("aram_fill", 32'(aram_fill), 32'(fill_ref(aram_pat, clear_addr)));
		end
	end

	initial begin
		int n;
		int i;
		RESET = 1'b1;
		dl_download = 1'b0;
		dl_index = 8'h00;
		dl_addr = 25'd0;
		dl_data = 16'h0000;
		dl_wr = 1'b0;
		hdr_mode = 3'd0;
		region_opt = 2'd0;
		wram_pat = 2'd0;
		aram_pat = 2'd1;

		// Reset state
		repeat (7) @(posedge clk_sys);
		@(negedge clk_sys);
		check("core_reset in reset", 32'(core_reset), 32'd1);
		check("clear_busy in reset", 32'(clear_busy), 32'd0);
		check("clear_we in reset", 32'(clear_we), 32'd0);
		check("code_valid in reset", 32'(code_valid), 32'd0);
		check("code_reset in reset", 32'(code_reset), 32'd0);
		@(posedge clk_sys);
		#2;
		RESET = 1'b0;
		repeat (2) @(negedge clk_sys);
		check("core_reset idle", 32'(core_reset), 32'd0);

		// Sound program holds the core but starts no clear
		begin_download(8'h04);
		repeat (2) @(negedge clk_sys);
		check("core_reset spc", 32'(core_reset), 32'd1);
		check("clear_busy spc", 32'(clear_busy), 32'd0);
		end_download();
		repeat (2) @(negedge clk_sys);
		check("core_reset after spc", 32'(core_reset), 32'd0);

		// Header detection
		load_header(3'd0, 8'h01, 16'h233A, 25'd0, 4'h0, 4'h0);
		check_header(8'h23, 4'hA, 4'h3);
		check("pal region bit", 32'(pal), 32'd1);
		@(posedge clk_sys);
		#2;
		region_opt = 2'd1;
		repeat (2) @(negedge clk_sys);
		check("pal ntsc", 32'(pal), 32'd0);
		@(posedge clk_sys);
		#2;
		region_opt = 2'd2;
		repeat (2) @(negedge clk_sys);
		check("pal forced", 32'(pal), 32'd1);
		@(posedge clk_sys);
		#2;
		region_opt = 2'd0;
		load_header(3'd3, 8'h00, 16'h55AA, `HDR_HI_SIZE_ADDR, 4'hB, 4'h5);
		check_header(8'h01, 4'hB, 4'h5);
		load_header(3'd4, 8'h41, 16'h1234, `HDR_EX_SIZE_ADDR, 4'hD, 4'h7);
		check_header(8'h02, 4'hD, 4'h7);
		load_header(3'd1, 8'h01, 16'hFFFF, 25'd0, 4'h0, 4'h0);
		check_header(8'h00, 4'hC, 4'h0);

		// RAM clear with every fill pattern on both RAMs
		n = 0;
		while (clear_busy && n < SWEEP_CYCLES + 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (clear_busy)
			timed_out("earlier clear to finish");
		run_sweep(2'd0, 2'd1);
		run_sweep(2'd1, 2'd0);
		run_sweep(2'd2, 2'd3);
		run_sweep(2'd3, 2'd2);

		// Cheat record
		valid_count = 0;
		begin_download(8'hFF);
		for (i = 0; i < 8; i++) begin
			code_words[3'(i)] = 16'($random(seed));
			write_word(25'(i * 2), code_words[3'(i)]);
			if (i == 0) begin
				n = 0;
				while (!code_reset && n < 4) begin
					@(negedge clk_sys);
					n++;
				end
				if (!code_reset)
					timed_out("code_reset");
			end
		end
		n = 0;
		while (!code_valid && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (!code_valid)
			timed_out("code_valid");
		end_download();
		@(negedge clk_sys);
		check("code_valid pulses", valid_count, 32'd1);
		check("code_reset idle", 32'(code_reset), 32'd0);
		check("code_flags", code_flags, record_field(code_words, 2'd0));
		check("code_addr", code_addr, record_field(code_words, 2'd1));
		check("code_cmp", code_cmp, record_field(code_words, 2'd2));
		check("code_repl", code_repl, record_field(code_words, 2'd3));

		repeat (2) @(posedge clk_sys);
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, i_cart_loader_top.i_cart_loader_sva.fails);
		if (errors == 0 && timeouts == 0 && i_cart_loader_top.i_cart_loader_sva.fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
